/* verilog.f */
logic/cfg_pkg.sv
logic/cfg_regfile.sv
logic/cfg_mgmt_arbiter.sv
logic/status_clear_timer.sv
logic/cfg_top.sv
bench/cfg_core_model.sv
bench/cfg_top_tb.sv

/* Makefile */
# Verilator lint and simulation of the PCIe config-control block
TOP := cfg_top_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

/* bench/cfg_top_tb.sv */
// Testbench for cfg_top; random host commands checked against a register mirror and a core model
`timescale 1ns/100ps

module cfg_top_tb;

    localparam int PERIOD_RESET = 40;
    // About 600 commands at up to 30 cycles each, plus idle time for the timer test
    localparam int MAX_CYCLES = 600 * 30 + 2000;

    logic clk_pcie;
    logic rst;
    logic i_cmd_valid, o_cmd_ready, o_rsp_valid, i_rsp_ready;
    cfg_pkg::cmd_word_t i_cmd_data;
    cfg_pkg::rsp_word_t o_rsp_data;
    logic [15:0]        i_pcie_id;
    logic cfg_rd_en, cfg_wr_en, cfg_readonly, cfg_rw1c, cfg_done;
    cfg_pkg::dwaddr_t   cfg_dwaddr, last_dwaddr;
    cfg_pkg::dword_t    cfg_di, cfg_do, last_data;
    cfg_pkg::byte_en_t  cfg_byte_en, last_byte_en;
    int unsigned        wr_count;

    logic [159:0]       rw_mirror;      // Expected read-write half
    logic [1:0]         wr_flags [16];  // rw1c and readonly seen with each write, per dword
    cfg_pkg::rsp_word_t rsp_q [$];
    logic               rand_ready = 1'b0;
    int unsigned        cycles = 0;
    int unsigned        checks = 0;
    int unsigned        errors = 0;
    int unsigned        chk0, err0;

    cfg_top #(.CLEAR_PERIOD_RESET(PERIOD_RESET)) dut (
        .clk_pcie, .rst,
        .i_cmd_valid, .o_cmd_ready, .i_cmd_data,
        .o_rsp_valid, .i_rsp_ready, .o_rsp_data, .i_pcie_id,
        .o_cfg_mgmt_rd_en         (cfg_rd_en),
        .o_cfg_mgmt_wr_en         (cfg_wr_en),
        .o_cfg_mgmt_dwaddr        (cfg_dwaddr),
        .o_cfg_mgmt_di            (cfg_di),
        .o_cfg_mgmt_byte_en       (cfg_byte_en),
        .o_cfg_mgmt_wr_readonly   (cfg_readonly),
        .o_cfg_mgmt_wr_rw1c_as_rw (cfg_rw1c),
        .i_cfg_mgmt_do            (cfg_do),
        .i_cfg_mgmt_rd_wr_done    (cfg_done)
    );

    cfg_core_model core (
        .clk_pcie, .rst,
        .i_rd_en (cfg_rd_en), .i_wr_en (cfg_wr_en), .i_dwaddr (cfg_dwaddr),
        .i_di (cfg_di), .i_byte_en (cfg_byte_en), .o_do (cfg_do), .o_done (cfg_done),
        .o_wr_count (wr_count), .o_last_dwaddr (last_dwaddr),
        .o_last_data (last_data), .o_last_byte_en (last_byte_en)
    );

    initial begin
        clk_pcie = 1'b0;
        forever #10 clk_pcie = ~clk_pcie;
    end

    always @(posedge clk_pcie) cycles <= cycles + 1;

    // Flags that went out with each write enable
    always @(negedge clk_pcie) begin
        if (cfg_wr_en) begin
            wr_flags[cfg_dwaddr[3:0]] <= {cfg_rw1c, cfg_readonly};
        end
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // Response sink; a word is taken when valid meets the ready set at this falling edge
    initial begin
        logic ready;
        forever begin
            @(negedge clk_pcie);
            ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
            i_rsp_ready = ready;
            if (o_rsp_valid && ready) begin
                rsp_q.push_back(o_rsp_data);
            end
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic cfg_pkg::half_t swap_bytes(input cfg_pkg::half_t h);
        return {h[7:0], h[15:8]};
    endfunction

    function automatic cfg_pkg::cmd_word_t make_cmd(input cfg_pkg::reg_addr_t addr,
            input cfg_pkg::half_t value, input cfg_pkg::half_t mask, input logic rd,
            input logic wr);
        cfg_pkg::cmd_word_t c;
        c = '0;
        c[63:48] = swap_bytes(value);
        c[47:32] = swap_bytes(mask);
        c[31:16] = addr;
        c[13]    = wr;
        c[12]    = rd;
        return c;
    endfunction

    // Expected 16-bit read value from the layout rules
    function automatic cfg_pkg::half_t expect_half(input cfg_pkg::reg_addr_t addr);
        int ofs;
        ofs = int'(addr[14:0]);
        if (ofs >= 20) return '0;
        if (addr[15]) return rw_mirror[8*ofs +: 16];
        case (ofs)
            'h0: return 16'h2301;
            'h4: return 16'd20;
            'he: return i_pcie_id;
            default: return '0;
        endcase
    endfunction

    task automatic send_cmd(input cfg_pkg::cmd_word_t cmd);
        @(negedge clk_pcie);
        i_cmd_valid = 1'b1;
        i_cmd_data  = cmd;
        #5;
        while (!o_cmd_ready) begin
            @(negedge clk_pcie);
            #5;
        end
        @(negedge clk_pcie);    // Transferred at the rising edge in between
        i_cmd_valid = 1'b0;
    endtask

    task automatic write_reg(input cfg_pkg::reg_addr_t addr, input cfg_pkg::half_t value,
            input cfg_pkg::half_t mask);
        int ofs;
        ofs = int'(addr[14:0]);
        send_cmd(make_cmd(addr, value, mask, 1'b0, 1'b1));
        if (addr[15] && ofs < 20) begin     // Read-only half ignores writes
            for (int i = 0; i < 16; i++) begin
                if (mask[i] && 8 * ofs + i < 160) rw_mirror[8*ofs + i] = value[i];
            end
        end
    endtask

    task automatic read_reg(input cfg_pkg::reg_addr_t addr, output cfg_pkg::rsp_word_t rsp);
        send_cmd(make_cmd(addr, '0, '0, 1'b1, 1'b0));
        while (rsp_q.size() == 0) @(negedge clk_pcie);
        rsp = rsp_q.pop_front();
    endtask

    task automatic check_rsp(input string name, input cfg_pkg::rsp_word_t exp,
            input cfg_pkg::rsp_word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_dword(input string name, input cfg_pkg::dword_t exp,
            input cfg_pkg::dword_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name, checks - chk0, errors - err0);
        chk0 = checks;
        err0 = errors;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    initial begin
        cfg_pkg::rsp_word_t rsp, rsp_hi;
        cfg_pkg::rsp_word_t exp_q [$];
        cfg_pkg::reg_addr_t addr;
        cfg_pkg::reg_addr_t id_addrs [5];
        cfg_pkg::reg_addr_t stable_addrs [12];
        cfg_pkg::half_t     value, mask;
        cfg_pkg::dword_t    data, expected;
        cfg_pkg::dwaddr_t   dwaddr;
        cfg_pkg::byte_en_t  be;
        logic [1:0]         flags;
        int unsigned        n, waited;
        void'($urandom(32'h5a09c5c2));
        rst         = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_data  = '0;
        i_rsp_ready = 1'b1;
        i_pcie_id   = 16'($urandom);
        rw_mirror   = '0;
        rw_mirror[15:0]       = 16'h6745;
        rw_mirror[19]         = 1'b1;       // Status-clear enable
        rw_mirror[20]         = 1'b1;       // Command-set enable
        rw_mirror[32 +: 32]   = 32'd20;
        rw_mirror[108 +: 4]   = 4'hf;
        rw_mirror[128 +: 32]  = PERIOD_RESET;
        chk0 = 0;
        err0 = 0;
        repeat (10) @(negedge clk_pcie);
        rst = 1'b0;

        id_addrs = '{16'h0000, 16'h0004, 16'h000e, 16'h8000, 16'h8004};
        foreach (id_addrs[i]) begin
            read_reg(id_addrs[i], rsp);
            check_rsp("id_reads", {id_addrs[i], swap_bytes(expect_half(id_addrs[i]))}, rsp);
        end
        report_test("id_reads");

        repeat (200) begin
            addr  = 16'h8008 + 16'(2 * $urandom_range(3, 0));
            value = 16'($urandom);
            mask  = 16'($urandom);
            if ($urandom_range(3, 0) == 0) write_reg(addr & 16'h7fff, value, mask);
            else write_reg(addr, value, mask);
            read_reg(addr, rsp);
            check_rsp("rw_masked", {addr, swap_bytes(expect_half(addr))}, rsp);
        end
        report_test("rw_masked");

        dwaddr = 10'(2 + $urandom_range(13, 0));  // Dword 1 belongs to the timer
        data   = $urandom;
        be     = 4'($urandom_range(15, 1));
        flags  = 2'($urandom_range(3, 1));        // Nonzero, timer writes must not carry them
        write_reg(16'h8008, data[15:0], 16'hffff);
        write_reg(16'h800a, data[31:16], 16'hffff);
        write_reg(16'h800c, {be, flags, dwaddr}, 16'hffff);
        expected = core.mem[dwaddr[3:0]];
        for (int b = 0; b < 4; b++) begin
            if (be[b]) expected[8*b +: 8] = data[8*b +: 8];
        end
        write_reg(16'h8002, 16'h0006, 16'h0006);   // Write start with wait-complete
        read_reg(16'h000c, rsp);                    // Held off until the write is done
        rw_mirror[17:16] = 2'b00;
        check_rsp("cfg_write", {16'h000c, swap_bytes({be, 2'b10, dwaddr})}, rsp);
        check_dword("cfg_write flags", {30'h0, flags}, {30'h0, wr_flags[dwaddr[3:0]]});
        write_reg(16'h8002, 16'h0005, 16'h0005);
        read_reg(16'h000c, rsp);
        rw_mirror[17:16] = 2'b00;
        check_rsp("cfg_read", {16'h000c, swap_bytes({be, 2'b10, dwaddr})}, rsp);
        read_reg(16'h0008, rsp);
        read_reg(16'h000a, rsp_hi);
        check_dword("cfg_write_read", expected,
                    {swap_bytes(rsp_hi[15:0]), swap_bytes(rsp[15:0])});
        report_test("cfg_write_read");

        // Addresses whose contents do not move under timer traffic
        stable_addrs = '{16'h0000, 16'h0004, 16'h0006, 16'h000e, 16'h0010, 16'h0016,
                         16'h8000, 16'h8002, 16'h8008, 16'h800c, 16'h8010, 16'h801e};
        rand_ready = 1'b1;
        repeat (100) begin
            addr = stable_addrs[$urandom_range(11, 0)];
            exp_q.push_back({addr, swap_bytes(expect_half(addr))});
            send_cmd(make_cmd(addr, '0, '0, 1'b1, 1'b0));
        end
        while (rsp_q.size() < 100) @(negedge clk_pcie);
        rand_ready = 1'b0;
        repeat (4) @(negedge clk_pcie);
        checks++;
        if (rsp_q.size() != 100) begin
            errors++;
            $display("rsp_backpressure: %0d responses for 100 reads", rsp_q.size());
        end else begin
            while (exp_q.size() > 0) check_rsp("rsp_backpressure", exp_q.pop_front(),
                                               rsp_q.pop_front());
        end
        report_test("rsp_backpressure");

        n      = wr_count;
        waited = 0;
        while (wr_count == n && waited < 5 * PERIOD_RESET) begin
            @(negedge clk_pcie);
            waited++;
        end
        if (wr_count == n) begin
            checks++;
            errors++;
            $display("status_clear: no automatic write while the host was idle");
        end else begin
            check_dword("status_clear data", 32'hff000105, last_data);
            check_dword("status_clear addr", {18'h0, 4'b1011, 10'd1},
                        {18'h0, last_byte_en, last_dwaddr});
            check_dword("status_clear flags", 32'h0, {30'h0, wr_flags[1]});
        end
        write_reg(16'h8002, 16'h0000, 16'h0018);   // Both enables off
        repeat (20) @(negedge clk_pcie);
        n = wr_count;
        repeat (5 * PERIOD_RESET) @(negedge clk_pcie);
        checks++;
        if (wr_count != n) begin
            errors++;
            $display("status_clear: automatic write after both enables were cleared");
        end
        report_test("status_clear");

        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* bench/cfg_core_model.sv */
// Behavioral PCIe core config-management port for the testbench; 16 dwords, random done delay
`timescale 1ns/100ps

module cfg_core_model (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                i_rd_en,
    input  logic                i_wr_en,
    input  cfg_pkg::dwaddr_t    i_dwaddr,
    input  cfg_pkg::dword_t     i_di,
    input  cfg_pkg::byte_en_t   i_byte_en,
    output cfg_pkg::dword_t     o_do,
    output logic                o_done,
    output int unsigned         o_wr_count,
    output cfg_pkg::dwaddr_t    o_last_dwaddr,
    output cfg_pkg::dword_t     o_last_data,
    output cfg_pkg::byte_en_t   o_last_byte_en
);

    cfg_pkg::dword_t mem [16];
    logic            busy;
    logic            is_write;
    int unsigned     delay;

    initial begin
        o_do       = '0;
        o_done     = 1'b0;
        o_wr_count = 0;
    end

    always @(posedge clk_pcie) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= 32'h9e3779b9 * (i + 1);   // Fill pattern per dword
            end
            busy       <= 1'b0;
            is_write   <= 1'b0;
            o_done     <= 1'b0;
            o_do       <= '0;
            o_wr_count <= 0;
        end else begin
            o_done <= 1'b0;
            if (!busy) begin
                if (i_rd_en || i_wr_en) begin
                    busy     <= 1'b1;
                    is_write <= i_wr_en;
                    delay    <= $urandom_range(8, 1);
                end
            end else if (o_done) begin
                busy <= 1'b0;       // Enable is gated off in the done cycle
            end else if (delay > 1) begin
                delay <= delay - 1;
            end else begin
                o_done <= 1'b1;
                if (is_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_byte_en[b]) begin
                            mem[i_dwaddr[3:0]][8*b +: 8] <= i_di[8*b +: 8];
                        end
                    end
                    o_wr_count     <= o_wr_count + 1;
                    o_last_dwaddr  <= i_dwaddr;
                    o_last_data    <= i_di;
                    o_last_byte_en <= i_byte_en;
                end else begin
                    o_do <= mem[i_dwaddr[3:0]];     // Data out only changes on reads
                end
            end
        end
    end

endmodule

/* logic/cfg_top.sv */
// Top level of the PCIe config-control block; wires register file, timer and arbiter
`timescale 1ns/100ps

module cfg_top #(
    parameter cfg_pkg::period_t CLEAR_PERIOD_RESET = 62500
) (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                i_cmd_valid,
    output logic                o_cmd_ready,
    input  cfg_pkg::cmd_word_t  i_cmd_data,
    output logic                o_rsp_valid,
    input  logic                i_rsp_ready,
    output cfg_pkg::rsp_word_t  o_rsp_data,
    input  logic [15:0]         i_pcie_id,
    output logic                o_cfg_mgmt_rd_en,
    output logic                o_cfg_mgmt_wr_en,
    output cfg_pkg::dwaddr_t    o_cfg_mgmt_dwaddr,
    output cfg_pkg::dword_t     o_cfg_mgmt_di,
    output cfg_pkg::byte_en_t   o_cfg_mgmt_byte_en,
    output logic                o_cfg_mgmt_wr_readonly,
    output logic                o_cfg_mgmt_wr_rw1c_as_rw,
    input  cfg_pkg::dword_t     i_cfg_mgmt_do,
    input  logic                i_cfg_mgmt_rd_wr_done
);

    // Host request path
    logic host_req_valid, host_req_write, host_readonly, host_rw1c, host_ready;
    cfg_pkg::dwaddr_t  host_dwaddr;
    cfg_pkg::dword_t   host_di;
    cfg_pkg::byte_en_t host_byte_en;

    // Timer path
    logic timer_req_valid, timer_ready, cmd_fire, clear_en, cmd_set_en;
    cfg_pkg::byte_en_t timer_byte_en;
    cfg_pkg::period_t  clear_period;

    // Arbiter status and result
    logic bus_busy, rd_busy, wr_busy, result_valid;
    cfg_pkg::dword_t   result_data;
    cfg_pkg::dwaddr_t  result_dwaddr;
    cfg_pkg::byte_en_t result_byte_en;

    cfg_regfile #(
        .CLEAR_PERIOD_RESET(CLEAR_PERIOD_RESET)
    ) u_regfile (
        .clk_pcie, .rst,
        .i_cmd_valid, .o_cmd_ready, .i_cmd_data,
        .o_rsp_valid, .i_rsp_ready, .o_rsp_data,
        .i_pcie_id,
        .i_bus_busy       (bus_busy),
        .i_rd_busy        (rd_busy),
        .i_wr_busy        (wr_busy),
        .i_host_ready     (host_ready),
        .i_result_valid   (result_valid),
        .i_result_data    (result_data),
        .i_result_dwaddr  (result_dwaddr),
        .i_result_byte_en (result_byte_en),
        .o_host_req_valid (host_req_valid),
        .o_host_req_write (host_req_write),
        .o_host_dwaddr    (host_dwaddr),
        .o_host_di        (host_di),
        .o_host_byte_en   (host_byte_en),
        .o_host_readonly  (host_readonly),
        .o_host_rw1c      (host_rw1c),
        .o_cmd_fire       (cmd_fire),
        .o_clear_en       (clear_en),
        .o_cmd_set_en     (cmd_set_en),
        .o_clear_period   (clear_period)
    );

    status_clear_timer u_timer (
        .clk_pcie, .rst,
        .i_cmd_fire     (cmd_fire),
        .i_bus_busy     (bus_busy),
        .i_clear_en     (clear_en),
        .i_cmd_set_en   (cmd_set_en),
        .i_clear_period (clear_period),
        .i_ready        (timer_ready),
        .o_req_valid    (timer_req_valid),
        .o_byte_en      (timer_byte_en)
    );

    cfg_mgmt_arbiter u_arbiter (
        .clk_pcie, .rst,
        .i_host_req_valid  (host_req_valid),
        .i_host_req_write  (host_req_write),
        .i_host_dwaddr     (host_dwaddr),
        .i_host_di         (host_di),
        .i_host_byte_en    (host_byte_en),
        .i_host_readonly   (host_readonly),
        .i_host_rw1c       (host_rw1c),
        .i_timer_req_valid (timer_req_valid),
        .i_timer_byte_en   (timer_byte_en),
        .i_cfg_mgmt_do, .i_cfg_mgmt_rd_wr_done,
        .o_host_ready      (host_ready),
        .o_timer_ready     (timer_ready),
        .o_bus_busy        (bus_busy),
        .o_rd_busy         (rd_busy),
        .o_wr_busy         (wr_busy),
        .o_result_valid    (result_valid),
        .o_result_data     (result_data),
        .o_result_dwaddr   (result_dwaddr),
        .o_result_byte_en  (result_byte_en),
        .o_cfg_mgmt_rd_en, .o_cfg_mgmt_wr_en,
        .o_cfg_mgmt_dwaddr, .o_cfg_mgmt_di, .o_cfg_mgmt_byte_en,
        .o_cfg_mgmt_wr_readonly, .o_cfg_mgmt_wr_rw1c_as_rw
    );

endmodule

/* logic/status_clear_timer.sv */
// Idle-cycle counter that requests the automatic command/status register write
`timescale 1ns/100ps

module status_clear_timer (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                i_cmd_fire,
    input  logic                i_bus_busy,
    input  logic                i_clear_en,
    input  logic                i_cmd_set_en,
    input  cfg_pkg::period_t    i_clear_period,
    input  logic                i_ready,
    output logic                o_req_valid,
    output cfg_pkg::byte_en_t   o_byte_en
);

    cfg_pkg::period_t count_q;
    logic             enabled;
    logic             advance;

    assign enabled = i_clear_en | i_cmd_set_en;
    // Host traffic and bus activity hold the count
    assign advance = enabled & ~i_cmd_fire & ~i_bus_busy & ~o_req_valid;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            count_q     <= '0;
            o_req_valid <= 1'b0;
        end else begin
            if (!enabled) begin
                count_q <= '0;
            end else if (advance) begin
                if (count_q > i_clear_period) begin
                    count_q     <= '0;
                    o_req_valid <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
            if (i_ready) begin
                o_req_valid <= 1'b0;
            end
        end
    end

    // Status byte only with clear enable, command bytes only with set enable
    always_ff @(posedge clk_pcie) begin
        if (advance && count_q > i_clear_period) begin
            o_byte_en <= {i_clear_en, 1'b0, i_cmd_set_en, i_cmd_set_en};
        end
    end

endmodule

/* logic/cfg_mgmt_arbiter.sv */
// Grants the core's config-management port to the host or the timer and runs the handshake
`timescale 1ns/100ps

module cfg_mgmt_arbiter (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                i_host_req_valid,
    input  logic                i_host_req_write,
    input  cfg_pkg::dwaddr_t    i_host_dwaddr,
    input  cfg_pkg::dword_t     i_host_di,
    input  cfg_pkg::byte_en_t   i_host_byte_en,
    input  logic                i_host_readonly,
    input  logic                i_host_rw1c,
    input  logic                i_timer_req_valid,
    input  cfg_pkg::byte_en_t   i_timer_byte_en,
    input  cfg_pkg::dword_t     i_cfg_mgmt_do,
    input  logic                i_cfg_mgmt_rd_wr_done,
    output logic                o_host_ready,
    output logic                o_timer_ready,
    output logic                o_bus_busy,
    output logic                o_rd_busy,
    output logic                o_wr_busy,
    output logic                o_result_valid,
    output cfg_pkg::dword_t     o_result_data,
    output cfg_pkg::dwaddr_t    o_result_dwaddr,
    output cfg_pkg::byte_en_t   o_result_byte_en,
    output logic                o_cfg_mgmt_rd_en,
    output logic                o_cfg_mgmt_wr_en,
    output cfg_pkg::dwaddr_t    o_cfg_mgmt_dwaddr,
    output cfg_pkg::dword_t     o_cfg_mgmt_di,
    output cfg_pkg::byte_en_t   o_cfg_mgmt_byte_en,
    output logic                o_cfg_mgmt_wr_readonly,
    output logic                o_cfg_mgmt_wr_rw1c_as_rw
);

    cfg_pkg::arb_state_t state_q;
    logic rd_en_q;
    logic wr_en_q;

    assign o_host_ready  = (state_q == cfg_pkg::ARB_IDLE) & i_host_req_valid;    // Host first
    assign o_timer_ready = (state_q == cfg_pkg::ARB_IDLE) & ~i_host_req_valid & i_timer_req_valid;
    assign o_bus_busy    = state_q != cfg_pkg::ARB_IDLE;
    assign o_rd_busy     = rd_en_q;
    assign o_wr_busy     = wr_en_q;

    // Enables drop in the done cycle itself
    assign o_cfg_mgmt_rd_en = rd_en_q & ~i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt_wr_en = wr_en_q & ~i_cfg_mgmt_rd_wr_done;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            state_q        <= cfg_pkg::ARB_IDLE;
            rd_en_q        <= 1'b0;
            wr_en_q        <= 1'b0;
            o_result_valid <= 1'b0;
        end else begin
            case (state_q)
                cfg_pkg::ARB_IDLE: begin
                    if (o_host_ready) begin
                        state_q        <= cfg_pkg::ARB_HOST;
                        rd_en_q        <= ~i_host_req_write;
                        wr_en_q        <= i_host_req_write;
                        o_result_valid <= 1'b0;
                    end else if (o_timer_ready) begin
                        state_q        <= cfg_pkg::ARB_TIMER;
                        wr_en_q        <= 1'b1;    // Timer only writes
                        o_result_valid <= 1'b0;
                    end
                end
                default: begin
                    if (i_cfg_mgmt_rd_wr_done) begin
                        state_q        <= cfg_pkg::ARB_IDLE;
                        rd_en_q        <= 1'b0;
                        wr_en_q        <= 1'b0;
                        o_result_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Request fields latched at grant, result at done
    always_ff @(posedge clk_pcie) begin
        if (o_host_ready) begin
            o_cfg_mgmt_dwaddr        <= i_host_dwaddr;
            o_cfg_mgmt_di            <= i_host_di;
            o_cfg_mgmt_byte_en       <= i_host_byte_en;
            o_cfg_mgmt_wr_readonly   <= i_host_readonly;
            o_cfg_mgmt_wr_rw1c_as_rw <= i_host_rw1c;
        end else if (o_timer_ready) begin
            o_cfg_mgmt_dwaddr        <= cfg_pkg::CLEAR_DWADDR;
            o_cfg_mgmt_di            <= cfg_pkg::CLEAR_DATA;
            o_cfg_mgmt_byte_en       <= i_timer_byte_en;
            o_cfg_mgmt_wr_readonly   <= 1'b0;
            o_cfg_mgmt_wr_rw1c_as_rw <= 1'b0;
        end
        if (o_bus_busy && i_cfg_mgmt_rd_wr_done) begin
            o_result_data    <= i_cfg_mgmt_do;
            o_result_dwaddr  <= o_cfg_mgmt_dwaddr;
            o_result_byte_en <= o_cfg_mgmt_byte_en;
        end
    end

    // Never both enables at once
    assert property (@(posedge clk_pcie) disable iff (rst)
        !(o_cfg_mgmt_rd_en && o_cfg_mgmt_wr_en));

endmodule

/* logic/cfg_regfile.sv */
// Host command decoder and register file; launches config requests and returns reads
`timescale 1ns/100ps

module cfg_regfile #(
    parameter cfg_pkg::period_t CLEAR_PERIOD_RESET = 62500
) (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                i_cmd_valid,
    output logic                o_cmd_ready,
    input  cfg_pkg::cmd_word_t  i_cmd_data,
    output logic                o_rsp_valid,
    input  logic                i_rsp_ready,
    output cfg_pkg::rsp_word_t  o_rsp_data,
    input  logic [15:0]         i_pcie_id,
    input  logic                i_bus_busy,
    input  logic                i_rd_busy,
    input  logic                i_wr_busy,
    input  logic                i_host_ready,
    input  logic                i_result_valid,
    input  cfg_pkg::dword_t     i_result_data,
    input  cfg_pkg::dwaddr_t    i_result_dwaddr,
    input  cfg_pkg::byte_en_t   i_result_byte_en,
    output logic                o_host_req_valid,
    output logic                o_host_req_write,
    output cfg_pkg::dwaddr_t    o_host_dwaddr,
    output cfg_pkg::dword_t     o_host_di,
    output cfg_pkg::byte_en_t   o_host_byte_en,
    output logic                o_host_readonly,
    output logic                o_host_rw1c,
    output logic                o_cmd_fire,
    output logic                o_clear_en,
    output logic                o_cmd_set_en,
    output cfg_pkg::period_t    o_clear_period
);

    // Bit positions inside the RW half
    localparam int RD_START  = 8 * cfg_pkg::RW_OFS_CTRL;
    localparam int WR_START  = RD_START + 1;
    localparam int WAIT_CMPL = RD_START + 2;
    localparam int CLR_EN    = RD_START + 3;
    localparam int SET_EN    = RD_START + 4;
    localparam int ADDR_LSB  = 8 * cfg_pkg::RW_OFS_ADDR;

    logic [cfg_pkg::RW_BITS-1:0] rw_q;
    logic [cfg_pkg::RO_BITS-1:0] ro;
    logic [cfg_pkg::RO_BITS+15:0] rd_pad;   // Room for a 16-bit slice at the top byte

    cfg_pkg::reg_addr_t cmd_addr;
    cfg_pkg::half_t     cmd_value;
    cfg_pkg::half_t     cmd_mask;
    cfg_pkg::half_t     rd_half;
    logic               cmd_read;
    logic               cmd_write;
    logic               addr_hit;
    logic [7:0]         bit_base;

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------
    assign cmd_addr  = i_cmd_data[31:16];
    assign cmd_value = {i_cmd_data[55:48], i_cmd_data[63:56]};  // Byte swapped on the wire
    assign cmd_mask  = {i_cmd_data[39:32], i_cmd_data[47:40]};
    assign cmd_read  = o_cmd_fire & i_cmd_data[12];
    assign cmd_write = o_cmd_fire & i_cmd_data[13] & cmd_addr[15];
    assign addr_hit  = cmd_addr[14:0] < 15'(cfg_pkg::REG_BYTES);
    assign bit_base  = {cmd_addr[4:0], 3'b000};

    assign o_cmd_ready = ~(o_rsp_valid & ~i_rsp_ready) &
                         ~(rw_q[WAIT_CMPL] & (rw_q[RD_START] | rw_q[WR_START] | i_bus_busy));
    assign o_cmd_fire  = i_cmd_valid & o_cmd_ready;

    // --------------------------------------------------
    // Read-only half
    // --------------------------------------------------
    always_comb begin
        ro = '0;    // Also covers the zero field at +10
        ro[8*cfg_pkg::RO_OFS_MAGIC +: 16]     = cfg_pkg::RO_MAGIC;
        ro[8*cfg_pkg::RO_OFS_BUSY]            = i_rd_busy;
        ro[8*cfg_pkg::RO_OFS_BUSY + 1]        = i_wr_busy;
        ro[8*cfg_pkg::RO_OFS_COUNT +: 32]     = cfg_pkg::REG_BYTES;
        ro[8*cfg_pkg::RO_OFS_RESULT +: 32]    = i_result_data;
        ro[8*cfg_pkg::RO_OFS_RES_ADDR +: 10]  = i_result_dwaddr;
        ro[8*cfg_pkg::RO_OFS_RES_ADDR + 11]   = i_result_valid;
        ro[8*cfg_pkg::RO_OFS_RES_ADDR + 12 +: 4] = i_result_byte_en;
        ro[8*cfg_pkg::RO_OFS_PCIE_ID +: 16]   = i_pcie_id;
        ro[8*cfg_pkg::RO_OFS_ZERO +: 32]      = '0;
    end

    assign rd_pad  = {16'h0000, (cmd_addr[15] ? rw_q : ro)};
    assign rd_half = addr_hit ? rd_pad[bit_base +: 16] : '0;    // Beyond 20 bytes reads zero

    // --------------------------------------------------
    // Read-write half
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            rw_q                                    <= '0;
            rw_q[8*cfg_pkg::RW_OFS_MAGIC +: 16]     <= cfg_pkg::RW_MAGIC;
            rw_q[CLR_EN]                            <= 1'b1;
            rw_q[SET_EN]                            <= 1'b1;
            rw_q[8*cfg_pkg::RW_OFS_COUNT +: 32]     <= cfg_pkg::REG_BYTES;
            rw_q[ADDR_LSB + 12 +: 4]                <= 4'hf;
            rw_q[8*cfg_pkg::RW_OFS_PERIOD +: 32]    <= CLEAR_PERIOD_RESET;
        end else begin
            // Granted start bit clears; a new host write in the same cycle wins
            if (i_host_ready) begin
                if (rw_q[RD_START]) begin
                    rw_q[RD_START] <= 1'b0;
                end else begin
                    rw_q[WR_START] <= 1'b0;
                end
            end
            if (cmd_write && addr_hit) begin
                for (int i = 0; i < 16; i++) begin
                    if (cmd_mask[i] && (int'(bit_base) + i < cfg_pkg::RW_BITS)) begin
                        rw_q[int'(bit_base) + i] <= cmd_value[i];
                    end
                end
            end
        end
    end

    assign o_host_req_valid = rw_q[RD_START] | rw_q[WR_START];
    assign o_host_req_write = ~rw_q[RD_START];      // Read first if both set
    assign o_host_di        = rw_q[8*cfg_pkg::RW_OFS_DATA +: 32];
    assign o_host_dwaddr    = rw_q[ADDR_LSB +: 10];
    assign o_host_readonly  = rw_q[ADDR_LSB + 10];
    assign o_host_rw1c      = rw_q[ADDR_LSB + 11];
    assign o_host_byte_en   = rw_q[ADDR_LSB + 12 +: 4];
    assign o_clear_en       = rw_q[CLR_EN];
    assign o_cmd_set_en     = rw_q[SET_EN];
    assign o_clear_period   = rw_q[8*cfg_pkg::RW_OFS_PERIOD +: 32];

    // --------------------------------------------------
    // Response
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            o_rsp_valid <= 1'b0;
        end else if (cmd_read) begin
            o_rsp_valid <= 1'b1;
        end else if (i_rsp_ready) begin
            o_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (cmd_read) begin
            o_rsp_data <= {cmd_addr, rd_half[7:0], rd_half[15:8]};
        end
    end

    // A held response keeps its data until taken
    assert property (@(posedge clk_pcie) disable iff (rst)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_data));

endmodule

/* logic/cfg_pkg.sv */
// Shared widths, register layout offsets and constants for the PCIe config-control block
package cfg_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    typedef logic [63:0] cmd_word_t;    // Host command word
    typedef logic [31:0] rsp_word_t;    // Read response word
    typedef logic [15:0] reg_addr_t;    // Byte address, bit 15 selects RW half
    typedef logic [15:0] half_t;
    typedef logic [31:0] dword_t;
    typedef logic [9:0]  dwaddr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [31:0] period_t;

    // --------------------------------------------------
    // Register file layout
    // --------------------------------------------------
    localparam int RO_BITS   = 160;
    localparam int RW_BITS   = 160;
    localparam int REG_BYTES = RO_BITS / 8;

    // Read-only half, byte offsets
    localparam int RO_OFS_MAGIC    = 'h0;
    localparam int RO_OFS_BUSY     = 'h2;
    localparam int RO_OFS_COUNT    = 'h4;
    localparam int RO_OFS_RESULT   = 'h8;
    localparam int RO_OFS_RES_ADDR = 'hc;
    localparam int RO_OFS_PCIE_ID  = 'he;
    localparam int RO_OFS_ZERO     = 'h10;

    // Read-write half, byte offsets
    localparam int RW_OFS_MAGIC  = 'h0;
    localparam int RW_OFS_CTRL   = 'h2;
    localparam int RW_OFS_COUNT  = 'h4;
    localparam int RW_OFS_DATA   = 'h8;
    localparam int RW_OFS_ADDR   = 'hc;
    localparam int RW_OFS_PERIOD = 'h10;

    localparam half_t RO_MAGIC = 16'h2301;
    localparam half_t RW_MAGIC = 16'h6745;

    // Automatic write: status do-not-update, command register set
    localparam dwaddr_t CLEAR_DWADDR = 10'd1;
    localparam dword_t  CLEAR_DATA   = 32'hff000105;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_HOST,
        ARB_TIMER
    } arb_state_t;

endpackage
